//--- Makefile
# Verilator build and run for the strided-access engine

VERILATOR  ?= verilator
TOP        ?= tb_addr_gen_top
LINT_TOP   ?= addr_gen_top
FILELIST   ?= addr_gen_top.f
OBJ_DIR    ?= obj_dir
VFLAGS     ?= --binary --timing -Wno-fatal
LINT_FLAGS ?= --lint-only -Wall --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(OBJ_DIR) -o V$(TOP)

# The simulator exits non-zero when the testbench stops with $fatal
run: build
	./$(OBJ_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(LINT_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

//--- addr_gen_top.f
+incdir+hw
hw/addr_gen_pkg.sv
hw/addr_gen_ifs.sv
hw/scratch_ram.sv
hw/scratch_arbiter.sv
hw/loop_addr_gen.sv
hw/addr_gen_top.sv
verif/tb_addr_gen_top.sv

//--- hw/addr_gen_consts.svh
`ifndef ADDR_GEN_CONSTS_SVH
`define ADDR_GEN_CONSTS_SVH

// Word address width, also the width of iteration counts and signed steps
`define ADDR_W 8

// Width of one scratchpad word
`define DATA_W 16

// Period and duty counters
`define PER_W 6

// Start delay counter
`define DELAY_W 5

// Number of words in the scratchpad
`define MEM_DEPTH 256

`endif

//--- hw/addr_gen_ifs.sv
`timescale 1ns/10ps

// Address stream from a generator, one step per cycle with valid and ready both high
interface agen_if;
   logic                valid;
   addr_gen_pkg::addr_t addr;
   logic                store;
   logic                ready;

   modport gen (
      output valid,
      output addr,
      output store,
      input  ready
   );

   modport sink (
      input  valid,
      input  addr,
      input  store,
      output ready
   );
endinterface

// Single-port scratchpad access, rdata follows a read enable by one cycle
interface ram_if;
   logic                en;
   logic                we;
   addr_gen_pkg::addr_t addr;
   addr_gen_pkg::data_t wdata;
   addr_gen_pkg::data_t rdata;

   modport ctrl (
      output en,
      output we,
      output addr,
      output wdata,
      input  rdata
   );

   modport mem (
      input  en,
      input  we,
      input  addr,
      input  wdata,
      output rdata
   );
endinterface

//--- hw/addr_gen_pkg.sv
`include "addr_gen_consts.svh"

package addr_gen_pkg;

   typedef logic        [`ADDR_W-1:0]  addr_t;
   typedef logic signed [`ADDR_W-1:0]  step_t;
   typedef logic        [`PER_W-1:0]   per_t;
   typedef logic        [`DELAY_W-1:0] delay_t;
   typedef logic        [`DATA_W-1:0]  data_t;

   // Register map of one generator, selected by the configuration port
   typedef enum logic [3:0] {
      START, DUTY,
      PER1, INCR1, ITER1, SHIFT1,
      PER2, INCR2, ITER2, SHIFT2,
      PER3, INCR3, ITER3, SHIFT3,
      DELAY, IGNORE_FIRST
   } cfg_field_e;

   // Channel select for configuration writes
   typedef enum logic {
      CH_RD,
      CH_WR
   } chan_e;

endpackage

//--- hw/addr_gen_top.sv
`timescale 1ns/10ps

module addr_gen_top (
   input  logic                     clk_i,
   input  logic                     rst_i,
   input  logic                     cfg_we_i,
   input  addr_gen_pkg::chan_e      cfg_chan_i,
   input  addr_gen_pkg::cfg_field_e cfg_field_i,
   input  addr_gen_pkg::addr_t      cfg_data_i,
   input  logic                     run_rd_i,
   input  logic                     run_wr_i,
   output logic                     rd_valid_o,
   output addr_gen_pkg::data_t      rd_data_o,
   input  addr_gen_pkg::data_t      wr_data_i,
   output logic                     wr_take_o,
   output logic                     done_rd_o,
   output logic                     done_wr_o
);

   logic cfg_we_rd;
   logic cfg_we_wr;

   agen_if rd_if ();
   agen_if wr_if ();
   ram_if  ram_bus ();

   // Configuration writes go to the channel they name
   assign cfg_we_rd = cfg_we_i && (cfg_chan_i == addr_gen_pkg::CH_RD);
   assign cfg_we_wr = cfg_we_i && (cfg_chan_i == addr_gen_pkg::CH_WR);

   loop_addr_gen u_rd_gen (
      .clk_i       (clk_i),
      .rst_i       (rst_i),
      .cfg_we_i    (cfg_we_rd),
      .cfg_field_i (cfg_field_i),
      .cfg_data_i  (cfg_data_i),
      .run_i       (run_rd_i),
      .done_o      (done_rd_o),
      .agen        (rd_if.gen)
   );

   loop_addr_gen u_wr_gen (
      .clk_i       (clk_i),
      .rst_i       (rst_i),
      .cfg_we_i    (cfg_we_wr),
      .cfg_field_i (cfg_field_i),
      .cfg_data_i  (cfg_data_i),
      .run_i       (run_wr_i),
      .done_o      (done_wr_o),
      .agen        (wr_if.gen)
   );

   scratch_arbiter u_arb (
      .clk_i      (clk_i),
      .rst_i      (rst_i),
      .rd_gen     (rd_if.sink),
      .wr_gen     (wr_if.sink),
      .wr_data_i  (wr_data_i),
      .wr_take_o  (wr_take_o),
      .rd_valid_o (rd_valid_o),
      .rd_data_o  (rd_data_o),
      .ram        (ram_bus.ctrl)
   );

   scratch_ram u_ram (
      .clk_i (clk_i),
      .ram   (ram_bus.mem)
   );

endmodule

//--- hw/loop_addr_gen.sv
`timescale 1ns/10ps
`include "addr_gen_consts.svh"

module loop_addr_gen (
   input  logic                     clk_i,
   input  logic                     rst_i,
   input  logic                     cfg_we_i,
   input  addr_gen_pkg::cfg_field_e cfg_field_i,
   input  addr_gen_pkg::addr_t      cfg_data_i,
   input  logic                     run_i,
   output logic                     done_o,
   agen_if.gen                      agen
);

   // Configuration registers
   addr_gen_pkg::addr_t  start_r;
   addr_gen_pkg::per_t   duty_r;
   addr_gen_pkg::per_t   per1_r, per2_r, per3_r;
   addr_gen_pkg::step_t  incr1_r, incr2_r, incr3_r;
   addr_gen_pkg::addr_t  iter1_r, iter2_r, iter3_r;
   addr_gen_pkg::step_t  shift1_r, shift2_r, shift3_r;
   addr_gen_pkg::delay_t delay_r;
   logic                 ignore_first_r;

   // Loop state
   addr_gen_pkg::delay_t delay_cnt;
   addr_gen_pkg::per_t   per1_q, per2_q, per3_q;
   addr_gen_pkg::addr_t  iter1_q, iter2_q, iter3_q;
   addr_gen_pkg::addr_t  addr_q, addr2_q, addr3_q;
   logic                 valid_q;
   logic                 ignore_q;
   logic                 done_q;

   logic per1_wrap, iter1_wrap;
   logic per2_wrap, iter2_wrap;
   logic per3_wrap, iter3_wrap;

   addr_gen_pkg::addr_t l2_incr, l2_shift;
   addr_gen_pkg::addr_t l3_incr, l3_shift;

   always_ff @(posedge clk_i or posedge rst_i) begin
      if (rst_i) begin
         start_r        <= '0;
         duty_r         <= '0;
         per1_r         <= '0;
         incr1_r        <= '0;
         iter1_r        <= '0;
         shift1_r       <= '0;
         per2_r         <= '0;
         incr2_r        <= '0;
         iter2_r        <= '0;
         shift2_r       <= '0;
         per3_r         <= '0;
         incr3_r        <= '0;
         iter3_r        <= '0;
         shift3_r       <= '0;
         delay_r        <= '0;
         ignore_first_r <= 1'b0;
      end else if (cfg_we_i) begin
         case (cfg_field_i)
            addr_gen_pkg::START:        start_r        <= cfg_data_i;
            addr_gen_pkg::DUTY:         duty_r         <= cfg_data_i[`PER_W-1:0];
            addr_gen_pkg::PER1:         per1_r         <= cfg_data_i[`PER_W-1:0];
            addr_gen_pkg::INCR1:        incr1_r        <= cfg_data_i;
            addr_gen_pkg::ITER1:        iter1_r        <= cfg_data_i;
            addr_gen_pkg::SHIFT1:       shift1_r       <= cfg_data_i;
            addr_gen_pkg::PER2:         per2_r         <= cfg_data_i[`PER_W-1:0];
            addr_gen_pkg::INCR2:        incr2_r        <= cfg_data_i;
            addr_gen_pkg::ITER2:        iter2_r        <= cfg_data_i;
            addr_gen_pkg::SHIFT2:       shift2_r       <= cfg_data_i;
            addr_gen_pkg::PER3:         per3_r         <= cfg_data_i[`PER_W-1:0];
            addr_gen_pkg::INCR3:        incr3_r        <= cfg_data_i;
            addr_gen_pkg::ITER3:        iter3_r        <= cfg_data_i;
            addr_gen_pkg::SHIFT3:       shift3_r       <= cfg_data_i;
            addr_gen_pkg::DELAY:        delay_r        <= cfg_data_i[`DELAY_W-1:0];
            addr_gen_pkg::IGNORE_FIRST: ignore_first_r <= cfg_data_i[0];
            default:                    ;
         endcase
      end
   end

   // A counter wraps on its last value; a programmed zero behaves as one
   assign per1_wrap  = (per1_r == '0) || ((per1_q + 1'b1) == per1_r);
   assign iter1_wrap = (iter1_r == '0) || ((iter1_q + 1'b1) == iter1_r);
   assign per2_wrap  = (per2_r == '0) || ((per2_q + 1'b1) == per2_r);
   assign iter2_wrap = (iter2_r == '0) || ((iter2_q + 1'b1) == iter2_r);
   assign per3_wrap  = (per3_r == '0) || ((per3_q + 1'b1) == per3_r);
   assign iter3_wrap = (iter3_r == '0) || ((iter3_q + 1'b1) == iter3_r);

   // Outer levels restart from their saved base, wrapping modulo the address space
   assign l2_incr  = addr2_q + incr2_r;
   assign l2_shift = addr2_q + shift2_r;
   assign l3_incr  = addr3_q + incr3_r;
   assign l3_shift = addr3_q + shift3_r;

   always_ff @(posedge clk_i or posedge rst_i) begin
      if (rst_i) begin
         delay_cnt <= '0;
         per1_q    <= '0;
         per2_q    <= '0;
         per3_q    <= '0;
         iter1_q   <= '0;
         iter2_q   <= '0;
         iter3_q   <= '0;
         addr_q    <= '0;
         addr2_q   <= '0;
         addr3_q   <= '0;
         valid_q   <= 1'b0;
         ignore_q  <= 1'b0;
         done_q    <= 1'b1;
      end else if (run_i) begin
         // Valid rises DELAY cycles after the pulse, at least one
         delay_cnt <= (delay_r == '0) ? '0 : delay_r - 1'b1;
         valid_q   <= (delay_r <= `DELAY_W'd1);
         per1_q    <= '0;
         per2_q    <= '0;
         per3_q    <= '0;
         iter1_q   <= '0;
         iter2_q   <= '0;
         iter3_q   <= '0;
         addr_q    <= start_r;
         addr2_q   <= start_r;
         addr3_q   <= start_r;
         ignore_q  <= ignore_first_r;
         done_q    <= 1'b0;
      end else if (delay_cnt != '0) begin
         delay_cnt <= delay_cnt - 1'b1;
         valid_q   <= (delay_cnt == `DELAY_W'd1);
      end else if (valid_q && agen.ready) begin
         // The innermost counter that has not reached its end takes the step
         if (!per1_wrap) begin
            if (agen.store) begin
               addr_q <= addr_q + incr1_r;
            end
            per1_q <= per1_q + 1'b1;
         end else if (!iter1_wrap) begin
            if (!ignore_q) begin
               addr_q <= addr_q + shift1_r;
            end
            per1_q   <= '0;
            iter1_q  <= iter1_q + 1'b1;
            ignore_q <= 1'b0;
         end else if (!per2_wrap) begin
            if (!ignore_q) begin
               addr_q  <= l2_incr;
               addr2_q <= l2_incr;
            end
            per1_q   <= '0;
            iter1_q  <= '0;
            per2_q   <= per2_q + 1'b1;
            ignore_q <= 1'b0;
         end else if (!iter2_wrap) begin
            if (!ignore_q) begin
               addr_q  <= l2_shift;
               addr2_q <= l2_shift;
            end
            per1_q   <= '0;
            iter1_q  <= '0;
            per2_q   <= '0;
            iter2_q  <= iter2_q + 1'b1;
            ignore_q <= 1'b0;
         end else if (!per3_wrap) begin
            if (!ignore_q) begin
               addr_q  <= l3_incr;
               addr2_q <= l3_incr;
               addr3_q <= l3_incr;
            end
            per1_q   <= '0;
            iter1_q  <= '0;
            per2_q   <= '0;
            iter2_q  <= '0;
            per3_q   <= per3_q + 1'b1;
            ignore_q <= 1'b0;
         end else if (!iter3_wrap) begin
            if (!ignore_q) begin
               addr_q  <= l3_shift;
               addr2_q <= l3_shift;
               addr3_q <= l3_shift;
            end
            per1_q   <= '0;
            iter1_q  <= '0;
            per2_q   <= '0;
            iter2_q  <= '0;
            per3_q   <= '0;
            iter3_q  <= iter3_q + 1'b1;
            ignore_q <= 1'b0;
         end else begin
            // Final step of every level
            valid_q <= 1'b0;
            done_q  <= 1'b1;
         end
      end
   end

   assign agen.valid = valid_q;
   assign agen.addr  = addr_q;
   assign agen.store = (per1_q < duty_r) && !ignore_q;
   assign done_o     = done_q;

endmodule

//--- hw/scratch_arbiter.sv
`timescale 1ns/10ps

module scratch_arbiter (
   input  logic                clk_i,
   input  logic                rst_i,
   agen_if.sink                rd_gen,
   agen_if.sink                wr_gen,
   input  addr_gen_pkg::data_t wr_data_i,
   output logic                wr_take_o,
   output logic                rd_valid_o,
   output addr_gen_pkg::data_t rd_data_o,
   ram_if.ctrl                 ram
);

   logic rd_req;
   logic wr_req;
   logic grant_rd;
   logic grant_wr;
   logic last_rd_q;
   logic rd_pend_q;

   // Only steps that store need the memory
   assign rd_req = rd_gen.valid && rd_gen.store;
   assign wr_req = wr_gen.valid && wr_gen.store;

   // On contention the channel that did not win last time goes first
   assign grant_rd = rd_req && (!wr_req || !last_rd_q);
   assign grant_wr = wr_req && (!rd_req || last_rd_q);

   // Gaps in the duty cycle complete at once and skip the RAM
   assign rd_gen.ready = !rd_gen.store || grant_rd;
   assign wr_gen.ready = !wr_gen.store || grant_wr;

   assign ram.en    = grant_rd || grant_wr;
   assign ram.we    = grant_wr;
   assign ram.addr  = grant_wr ? wr_gen.addr : rd_gen.addr;
   assign ram.wdata = wr_data_i;

   assign wr_take_o = grant_wr;

   always_ff @(posedge clk_i or posedge rst_i) begin
      if (rst_i) begin
         last_rd_q <= 1'b0;
      end else if (grant_rd || grant_wr) begin
         last_rd_q <= grant_rd;
      end
   end

   // Read data comes back one cycle after the grant
   always_ff @(posedge clk_i or posedge rst_i) begin
      if (rst_i) begin
         rd_pend_q <= 1'b0;
      end else begin
         rd_pend_q <= grant_rd;
      end
   end

   assign rd_valid_o = rd_pend_q;
   assign rd_data_o  = ram.rdata;

endmodule

//--- hw/scratch_ram.sv
`timescale 1ns/10ps
`include "addr_gen_consts.svh"

module scratch_ram (
   input logic clk_i,
   ram_if.mem  ram
);

   addr_gen_pkg::data_t mem [`MEM_DEPTH];

   // One port, so a write and a read never share a cycle
   always_ff @(posedge clk_i) begin
      if (ram.en) begin
         if (ram.we) begin
            mem[ram.addr] <= ram.wdata;
         end else begin
            ram.rdata <= mem[ram.addr];
         end
      end
   end

endmodule

//--- verif/addr_gen_stim.txt
// Records of 8 hex digits: 1cf000dd config write, 2c000000 clear channel c, 3000wwww write word
// 4000wwww expected read, 5m00ssll run mask m for ss steps, first read after ll cycles, f end
// Linear store of eight words at 0x10
21000000 11000010 11200008 11100008 11300001
3000a5c3 30000f1e 30007d29 30003b84 3000c64f 300058b0 3000e917 30002ad6
52000800
// Read-back of the same range
20000000 10000010 10200008 10100008 10300001
4000a5c3 40000f1e 40007d29 40003b84 4000c64f 400058b0 4000e917 40002ad6
51000800
// Fill 0xfe up to 0x0f, wrapping past the top of memory
21000000 110000fe 11200012 11100012 11300001
30003a7e 300091c4 30000b15 30007e22 3000c3d9 30005a60 3000e1f7 30002c8b 30009f03
300046ae 3000d257 300018e9 3000b73c 30006d41 3000f0a5 30008356 300027cd 30004b98
52001200
// Duty 2 of 4 with three iterations and shift 4
20000000 10000000 10200004 10100002 10300001 10400003 10500004
40000b15 40007e22 40009f03 400046ae 4000f0a5 40008356
51000c00
// Three levels of 2, incr2 of -3 and shift3 of 8, starting at 0x01
20000000 10000001 10200002 10100002 10300001 10400001
10600002 107000fd 10800001 10a00002 10b00004 10c00002 10d00008
40007e22 4000c3d9 40003a7e 400091c4 40002c8b 40009f03 4000c3d9 40005a60
40008356 400027cd 4000b73c 40006d41 40000f1e 40007d29 400027cd 40004b98
51001000
// Ignore-first with a start delay of 6
20000000 10000010 10200004 10100004 10300001 10400003 10500001 10e00006 10f00001
4000a5c3 40000f1e 40007d29 40003b84 4000c64f 400058b0 4000e917 40002ad6
51000c07
// Both channels at once, writes at 0x40 with stride 2 and reads of 0x00 to 0x0f
21000000 11000040 11200008 11100008 11300002
30006b2e 3000d04a 300019f5 30008c73 300042d8 3000f561 30003e9c 3000a70b
20000000 10000000 10200010 10100010 10300001
40000b15 40007e22 4000c3d9 40005a60 4000e1f7 40002c8b 40009f03 400046ae
4000d257 400018e9 4000b73c 40006d41 4000f0a5 40008356 400027cd 40004b98
53001800
// Read-back of the region written alongside
20000000 10000040 10200008 10100008 10300002
40006b2e 4000d04a 400019f5 40008c73 400042d8 4000f561 40003e9c 4000a70b
51000800
f0000000

//--- verif/tb_addr_gen_top.sv
`timescale 1ns/10ps

module tb_addr_gen_top;

   localparam int         STIM_DEPTH = 256;
   localparam logic [3:0] OP_CFG     = 4'h1;
   localparam logic [3:0] OP_CLEAR   = 4'h2;
   localparam logic [3:0] OP_WDATA   = 4'h3;
   localparam logic [3:0] OP_EXPECT  = 4'h4;
   localparam logic [3:0] OP_RUN     = 4'h5;
   localparam logic [3:0] OP_END     = 4'hf;

   logic                     clk;
   logic                     rst       = 1'b1;
   logic                     cfg_we    = 1'b0;
   addr_gen_pkg::chan_e      cfg_chan  = addr_gen_pkg::CH_RD;
   addr_gen_pkg::cfg_field_e cfg_field = addr_gen_pkg::START;
   addr_gen_pkg::addr_t      cfg_data  = '0;
   logic                     run_rd    = 1'b0;
   logic                     run_wr    = 1'b0;
   addr_gen_pkg::data_t      wr_data   = '0;
   logic                     rd_valid;
   addr_gen_pkg::data_t      rd_data;
   logic                     wr_take;
   logic                     done_rd;
   logic                     done_wr;

   logic [31:0]         stim [STIM_DEPTH];
   logic [31:0]         rec;
   int                  rec_idx;
   int                  cycle_cnt   = 0;
   int                  cycle_limit = 0;
   int                  min_lat     = 0;
   int                  since_run   = 0;
   int                  rd_idx      = 0;
   int                  wr_idx      = 0;
   addr_gen_pkg::data_t exp_list [$];
   addr_gen_pkg::data_t wr_list [$];
   logic [7:0]          lfsr_q      = 8'd68;
   logic [15:0]         filler;

   addr_gen_top u_dut (
      .clk_i       (clk),
      .rst_i       (rst),
      .cfg_we_i    (cfg_we),
      .cfg_chan_i  (cfg_chan),
      .cfg_field_i (cfg_field),
      .cfg_data_i  (cfg_data),
      .run_rd_i    (run_rd),
      .run_wr_i    (run_wr),
      .rd_valid_o  (rd_valid),
      .rd_data_o   (rd_data),
      .wr_data_i   (wr_data),
      .wr_take_o   (wr_take),
      .done_rd_o   (done_rd),
      .done_wr_o   (done_wr)
   );

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   // Galois form, taps for x^8 + x^6 + x^5 + x^4 + 1
   function automatic logic [7:0] lfsr_next(input logic [7:0] state);
      return state[0] ? ((state >> 1) ^ 8'hb8) : (state >> 1);
   endfunction

   task automatic abort_run(input string why);
      $display("%s", why);
      $display("TEST FAILED");
      $fatal(1, "simulation stopped on error");
   endtask

   task automatic check_equal(input logic [31:0] actual, input logic [31:0] expected,
                              input string what);
      if (actual !== expected) begin
         abort_run($sformatf("[FAIL] %0t ns: %s is %0h, expected %0h", $time, what, actual,
                             expected));
      end
   endtask

   task automatic write_cfg(input logic chan, input logic [3:0] field, input logic [7:0] data);
      @(posedge clk);
      cfg_we    <= 1'b1;
      cfg_chan  <= addr_gen_pkg::chan_e'(chan);
      cfg_field <= addr_gen_pkg::cfg_field_e'(field);
      cfg_data  <= data;
      @(posedge clk);
      cfg_we    <= 1'b0;
   endtask

   // Mask bit 0 starts the read channel and bit 1 the write channel
   task automatic run_channels(input logic [1:0] mask, input logic [7:0] lat);
      min_lat = int'(lat);
      @(posedge clk);
      run_rd <= mask[0];
      run_wr <= mask[1];
      @(posedge clk);
      run_rd <= 1'b0;
      run_wr <= 1'b0;
      do begin
         @(posedge clk);
      end while ((mask[0] && !done_rd) || (mask[1] && !done_wr));
      // The last read word arrives on the cycle that done rises
      @(posedge clk);
      check_equal(rd_idx, exp_list.size(), "read words returned so far");
      check_equal(wr_idx, wr_list.size(), "write words taken so far");
   endtask

   // Read monitor, also counting cycles since the last read run pulse
   always @(posedge clk) begin
      if (run_rd) begin
         since_run = 0;
      end else begin
         since_run++;
      end
      if (rd_valid) begin
         if (rd_idx >= exp_list.size()) begin
            abort_run("read channel returned more words than the stim file expects");
         end else begin
            check_equal(since_run >= min_lat, 1'b1, "read after the start delay");
            check_equal(rd_data, exp_list[rd_idx], $sformatf("read word %0d", rd_idx));
            rd_idx++;
         end
      end
   end

   // Write data follows the list, with LFSR filler on the idle bus
   always @(posedge clk) begin
      if (wr_take) begin
         if (wr_idx >= wr_list.size()) begin
            abort_run("write channel took a word beyond its data list");
         end else begin
            wr_idx++;
         end
      end
      if (wr_idx < wr_list.size()) begin
         wr_data <= wr_list[wr_idx];
      end else begin
         for (int b = 0; b < 16; b++) begin
            lfsr_q    = lfsr_next(lfsr_q);
            filler[b] = lfsr_q[0];
         end
         wr_data <= filler;
      end
   end

   always @(posedge clk) begin
      cycle_cnt++;
      if (cycle_cnt > cycle_limit) begin
         abort_run($sformatf("simulation timed out after %0d cycles", cycle_limit));
      end
   end

   initial begin
      for (int i = 0; i < STIM_DEPTH; i++) begin
         stim[i] = {OP_END, 28'h0};
      end
      $readmemh("verif/addr_gen_stim.txt", stim);

      // Forty cycles per generator step, and as many for every other record
      cycle_limit = 200;
      rec_idx     = 0;
      while (rec_idx < STIM_DEPTH && stim[rec_idx][31:28] != OP_END) begin
         if (stim[rec_idx][31:28] == OP_RUN) begin
            cycle_limit += 40 * int'(stim[rec_idx][15:8]);
         end else begin
            cycle_limit += 40;
         end
         rec_idx++;
      end

      repeat (5) @(posedge clk);
      rst <= 1'b0;
      @(posedge clk);
      check_equal(done_rd, 1'b1, "done_rd_o after reset");
      check_equal(done_wr, 1'b1, "done_wr_o after reset");
      check_equal(rd_valid, 1'b0, "rd_valid_o after reset");
      check_equal(wr_take, 1'b0, "wr_take_o after reset");

      rec_idx = 0;
      while (rec_idx < STIM_DEPTH && stim[rec_idx][31:28] != OP_END) begin
         rec = stim[rec_idx];
         case (rec[31:28])
            OP_CFG:    write_cfg(rec[24], rec[23:20], rec[7:0]);
            OP_CLEAR: begin
               for (int f = 0; f < 16; f++) begin
                  write_cfg(rec[24], f[3:0], 8'h00);
               end
            end
            OP_WDATA:  wr_list.push_back(rec[15:0]);
            OP_EXPECT: exp_list.push_back(rec[15:0]);
            OP_RUN:    run_channels(rec[25:24], rec[7:0]);
            default:   abort_run($sformatf("unknown stim record %h at entry %0d", rec, rec_idx));
         endcase
         rec_idx++;
      end

      if (rec_idx >= STIM_DEPTH) begin
         abort_run("stim file ended without an end record");
      end else begin
         $display("TEST OK");
         $finish;
      end
   end

endmodule
